/* src.f */
source/autosave_pkg.sv
source/activity_monitor.sv
source/backoff_scheduler.sv
source/upload_server.sv
source/autosave_top.sv
testbench/autosave_assert.sv
testbench/autosave_tb.sv

/* Makefile */
# Verilator build and run for the autosave controller

VERILATOR ?= verilator
TOP       ?= autosave_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/autosave_tb.sv */
// Autosave controller testbench
`default_nettype none

module autosave_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// DUT configuration for a short run
	localparam int prescale   = 4;
	localparam int min_ticks  = 4;
	localparam int max_ticks  = 32;
	localparam int idle_ticks = 8;
	localparam int rd_timeout = 16;
	localparam int max_reads  = 8;

	// Cycle limits of the phases
	localparam int quiet_cycles    = 200;
	localparam int req_limit       = (min_ticks + idle_ticks) * prescale + 4;
	// Floor plus two doublings plus two capped intervals
	localparam int cap_limit       = (7 * min_ticks + 2 * max_ticks) * prescale + 8;
	localparam int wait_limit      = rd_timeout + 3;
	localparam int upload_cycles   = max_reads * (wait_limit + 2) + 8;
	localparam int disabled_cycles = 400;
	localparam int budget = 16 + quiet_cycles + req_limit + upload_cycles + 16
		+ cap_limit + upload_cycles + disabled_cycles + 8;
	localparam int watch_cycles = budget * 12 / 10;

	logic clk_sys;
	logic reset;
	logic enable;
	logic save_ram_wr;
	logic user_active;
	logic core_wait;
	logic ioctl_upload;
	logic ioctl_rd;
	logic save_valid;
	logic ioctl_upload_req;
	logic ioctl_wait;
	logic save_rd;
	logic saving;
	autosave_pkg::save_data_t save_data;
	autosave_pkg::save_data_t ioctl_din;
	autosave_pkg::save_addr_t save_addr;

	integer seed = 32'he4a0_f48c;
	// Memory answers reads while set
	logic mem_answer;
	// User activity toggler on
	logic toggling;
	// Address of the read in flight
	autosave_pkg::save_addr_t exp_addr;

	autosave_top #(
		.prescale   (prescale),
		.min_ticks  (min_ticks),
		.max_ticks  (max_ticks),
		.idle_ticks (idle_ticks),
		.rd_timeout (rd_timeout)
	) autosave_top_i (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.enable           (enable),
		.save_ram_wr      (save_ram_wr),
		.user_active      (user_active),
		.core_wait        (core_wait),
		.ioctl_upload     (ioctl_upload),
		.ioctl_rd         (ioctl_rd),
		.save_valid       (save_valid),
		.save_data        (save_data),
		.ioctl_upload_req (ioctl_upload_req),
		.ioctl_din        (ioctl_din),
		.ioctl_wait       (ioctl_wait),
		.save_addr        (save_addr),
		.save_rd          (save_rd),
		.saving           (saving)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ------------------------------------------------------------------
	// Reporting and compare tasks
	// ------------------------------------------------------------------

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_data(input autosave_pkg::save_data_t got,
		input autosave_pkg::save_data_t exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("FAILED at %0t ns: %s, got %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_addr(input autosave_pkg::save_addr_t got,
		input autosave_pkg::save_addr_t exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("FAILED at %0t ns: %s, got %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("FAILED at %0t ns: %s, got %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
		return lo + ({$random(seed)} % (hi - lo + 1));
	endfunction

	// Memory contents are the low address byte XOR 5A
	function automatic autosave_pkg::save_data_t expected_data(
		input autosave_pkg::save_addr_t addr);
		return addr[7:0] ^ 8'h5A;
	endfunction

	// ------------------------------------------------------------------
	// Host side sequences
	// ------------------------------------------------------------------

	task automatic pulse_write();
		@(posedge clk_sys);
		save_ram_wr <= 1'b1;
		@(posedge clk_sys);
		save_ram_wr <= 1'b0;
	endtask

	task automatic wait_request(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (ioctl_upload_req !== 1'b1 && n < limit);
		if (ioctl_upload_req !== 1'b1) begin
			abort_run($sformatf("No upload request within %0d cycles of the save write",
				limit));
		end
	endtask

	// One host read that hangs when the memory stays silent
	task automatic host_read(input logic stuck);
		int n;
		autosave_pkg::save_data_t want;
		mem_answer = !stuck;
		@(posedge clk_sys);
		ioctl_rd <= 1'b1;
		@(posedge clk_sys);
		ioctl_rd <= 1'b0;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (ioctl_wait && n < wait_limit);
		if (ioctl_wait) begin
			abort_run($sformatf("Host read still waiting after %0d cycles", n));
		end
		// Wait was high on n - 1 sampled cycles
		if (stuck && n <= rd_timeout) begin
			abort_run($sformatf(
				"FAILED at %0t ns: stuck read released after %0d cycles, expected %0d",
				$time, n - 1, rd_timeout));
		end
		if (stuck) begin
			want = '0;
		end else begin
			want = expected_data(exp_addr);
		end
		check_data(ioctl_din, want, "host read data");
		exp_addr = exp_addr + 1'b1;
		mem_answer = 1'b1;
	endtask

	task automatic run_upload(input int reads, input int stuck_idx);
		int n;
		// Acknowledge the pending request
		@(posedge clk_sys);
		ioctl_upload <= 1'b1;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			check_bit(saving, 1'b1, "saving during upload");
		end while (ioctl_upload_req && n < 2);
		check_bit(ioctl_upload_req, 1'b0, "upload request after ioctl_upload rose");
		exp_addr = '0;
		for (int i = 0; i < reads; i++) begin
			host_read(i == stuck_idx);
		end
		@(posedge clk_sys);
		ioctl_upload <= 1'b0;
		@(negedge clk_sys);
		check_bit(saving, 1'b0, "saving after upload");
	endtask

	// Random core_wait outside uploads while no request may appear
	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(posedge clk_sys);
			core_wait <= (rand_range(0, 1) == 1);
			@(negedge clk_sys);
			check_bit(ioctl_upload_req, 1'b0, "upload request while clean or disabled");
			check_bit(save_rd, 1'b0, "save_rd outside upload");
			check_bit(ioctl_wait, core_wait, "ioctl_wait following core_wait");
		end
		@(posedge clk_sys);
		core_wait <= 1'b0;
	endtask

	// ------------------------------------------------------------------
	// Memory model, user toggler and watchdog
	// ------------------------------------------------------------------

	initial begin : memory_model
		int delay;
		autosave_pkg::save_addr_t addr;
		save_valid = 1'b0;
		save_data  = '0;
		forever begin
			@(negedge clk_sys);
			if (save_rd && mem_answer) begin
				addr = save_addr;
				check_addr(addr, exp_addr, "save memory read address");
				delay = rand_range(1, 6);
				repeat (delay) @(posedge clk_sys);
				save_valid <= 1'b1;
				save_data  <= expected_data(addr);
				@(posedge clk_sys);
				save_valid <= 1'b0;
			end
		end
	end

	// Toggle every 8 cycles so the user never goes idle
	initial begin : activity_toggler
		user_active = 1'b0;
		forever begin
			repeat (8) @(posedge clk_sys);
			if (toggling) begin
				user_active <= !user_active;
			end
		end
	end

	initial begin : run_watchdog
		repeat (watch_cycles) @(posedge clk_sys);
		abort_run($sformatf("Timeout, tests did not finish within %0d cycles", watch_cycles));
	end

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------

	initial begin : main_sequence
		reset        = 1'b1;
		enable       = 1'b1;
		save_ram_wr  = 1'b0;
		core_wait    = 1'b0;
		ioctl_upload = 1'b0;
		ioctl_rd     = 1'b0;
		mem_answer   = 1'b1;
		toggling     = 1'b0;
		exp_addr     = '0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;

		// Clean memory after reset never requests
		@(negedge clk_sys);
		check_bit(ioctl_upload_req, 1'b0, "upload request after reset");
		check_bit(save_rd, 1'b0, "save_rd after reset");
		check_bit(ioctl_wait, 1'b0, "ioctl_wait after reset");
		idle_cycles(quiet_cycles);

		// Save by an idle user with one stuck read
		pulse_write();
		wait_request(req_limit);
		run_upload(rand_range(3, max_reads), 1);

		// Busy user where the cap overrides the idle guard
		toggling = 1'b1;
		repeat (16) @(posedge clk_sys);
		pulse_write();
		wait_request(cap_limit);
		run_upload(rand_range(3, max_reads), -1);
		toggling = 1'b0;

		// Disabled controller stays silent though dirty
		@(posedge clk_sys);
		enable <= 1'b0;
		pulse_write();
		idle_cycles(disabled_cycles);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/autosave_assert.sv */
// Upload server protocol assertions
`default_nettype none

module autosave_assert (
	input logic                     clk_sys,
	input logic                     reset,
	input logic                     ioctl_upload,
	input logic                     save_rd,
	input logic                     save_wait,
	input autosave_pkg::save_data_t ioctl_din
);
	timeunit 1ns;
	timeprecision 100ps;

	// Memory read strobe lasts one cycle
	rd_single: assert property (@(posedge clk_sys) disable iff (reset)
		save_rd |=> !save_rd)
		else $error("save_rd held longer than one cycle");

	// Memory is only read during an upload
	rd_in_upload: assert property (@(posedge clk_sys) disable iff (reset)
		save_rd |-> ioctl_upload)
		else $error("save_rd outside an upload");

	// Host data holds while the read is pending
	din_stable: assert property (@(posedge clk_sys) disable iff (reset)
		save_wait && $past(save_wait) |-> $stable(ioctl_din))
		else $error("ioctl_din changed while save_wait was high");

endmodule

bind upload_server autosave_assert autosave_assert_i (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.ioctl_upload (ioctl_upload),
	.save_rd      (save_rd),
	.save_wait    (save_wait),
	.ioctl_din    (ioctl_din)
);

`default_nettype wire

/* source/autosave_top.sv */
// Autosave controller top level
`default_nettype none

module autosave_top #(
	parameter int unsigned prescale   = 50_000,
	parameter int unsigned min_ticks  = 1_000,
	parameter int unsigned max_ticks  = 30_000,
	parameter int unsigned idle_ticks = 1_000,
	parameter int unsigned addr_w     = autosave_pkg::addr_w_def,
	parameter int unsigned data_w     = autosave_pkg::data_w_def,
	parameter int unsigned rd_timeout = 1_000_000
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              enable,
	input  logic              save_ram_wr,
	input  logic              user_active,
	input  logic              core_wait,
	input  logic              ioctl_upload,
	input  logic              ioctl_rd,
	input  logic              save_valid,
	input  logic [data_w-1:0] save_data,
	output logic              ioctl_upload_req,
	output logic [data_w-1:0] ioctl_din,
	output logic              ioctl_wait,
	output logic [addr_w-1:0] save_addr,
	output logic              save_rd,
	output logic              saving
);

	logic tick;
	logic user_idle;
	logic save_wait;

	// ----------------------------------------------------------------------
	// Input side
	// ----------------------------------------------------------------------

	activity_monitor #(
		.prescale   (prescale),
		.idle_ticks (idle_ticks)
	) activity_monitor_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.user_active (user_active),
		.tick        (tick),
		.user_idle   (user_idle)
	);

	// Dirty check and upload request
	backoff_scheduler #(
		.min_ticks (min_ticks),
		.max_ticks (max_ticks)
	) backoff_scheduler_i (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.enable           (enable),
		.tick             (tick),
		.user_idle        (user_idle),
		.save_ram_wr      (save_ram_wr),
		.ioctl_upload     (ioctl_upload),
		.ioctl_upload_req (ioctl_upload_req)
	);

	// ----------------------------------------------------------------------
	// Output side
	// ----------------------------------------------------------------------

	upload_server #(
		.addr_w     (addr_w),
		.data_w     (data_w),
		.rd_timeout (rd_timeout)
	) upload_server_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ioctl_upload (ioctl_upload),
		.ioctl_rd     (ioctl_rd),
		.save_data    (save_data),
		.save_valid   (save_valid),
		.save_addr    (save_addr),
		.save_rd      (save_rd),
		.ioctl_din    (ioctl_din),
		.save_wait    (save_wait)
	);

	// Shared wait line, core download wait merged with the upload wait
	assign ioctl_wait = core_wait | save_wait;

	// Status for an OSD or LED indicator
	assign saving = ioctl_upload;

endmodule

`default_nettype wire

/* source/upload_server.sv */
// Save memory upload server
`default_nettype none

module upload_server #(
	parameter int unsigned addr_w     = 13,
	parameter int unsigned data_w     = 8,
	parameter int unsigned rd_timeout = 1_000_000
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              ioctl_upload,
	input  logic              ioctl_rd,
	input  logic [data_w-1:0] save_data,
	input  logic              save_valid,
	output logic [addr_w-1:0] save_addr,
	output logic              save_rd,
	output logic [data_w-1:0] ioctl_din,
	output logic              save_wait
);

	// Watchdog in raw clock cycles
	localparam int unsigned wd_w = $clog2(rd_timeout + 1);

	// Release after rd_timeout pending cycles
	localparam logic [wd_w-1:0] wd_load = wd_w'(rd_timeout - 1);

	autosave_pkg::serve_state_t state;

	logic [wd_w-1:0] watchdog;
	logic            rd_done;
	logic            timed_out;

	// ----------------------------------------------------------------------
	// Read completion
	// ----------------------------------------------------------------------

	// Memory answered, or the watchdog ran out
	assign rd_done = ioctl_upload && (state == autosave_pkg::serve_pending)
		&& (save_valid || watchdog == '0);

	// A late answer in the last cycle still wins
	assign timed_out = !save_valid && (watchdog == '0);

	// ----------------------------------------------------------------------
	// Serve FSM
	// ----------------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		// Strobe is a single cycle
		save_rd <= 1'b0;

		if (reset || !ioctl_upload) begin
			// Every upload starts again from address zero
			state     <= autosave_pkg::serve_idle;
			save_addr <= '0;
			save_wait <= 1'b0;
			watchdog  <= '0;
		end else begin
			case (state)
				autosave_pkg::serve_idle: begin
					if (ioctl_rd) begin
						save_rd   <= 1'b1;
						save_wait <= 1'b1;
						watchdog  <= wd_load;
						state     <= autosave_pkg::serve_pending;
					end
				end
				autosave_pkg::serve_pending: begin
					if (rd_done) begin
						save_addr <= save_addr + 1'b1;
						save_wait <= 1'b0;
						state     <= autosave_pkg::serve_idle;
					end else begin
						watchdog <= watchdog - 1'b1;
					end
				end
				default: state <= autosave_pkg::serve_idle;
			endcase
		end
	end

	// Host data, zero fill on a stuck read
	always_ff @(posedge clk_sys) begin
		if (rd_done) begin
			ioctl_din <= timed_out ? '0 : save_data;
		end
	end

endmodule

`default_nettype wire

/* source/backoff_scheduler.sv */
// Adaptive backoff save scheduler
`default_nettype none

module backoff_scheduler #(
	parameter int unsigned min_ticks = 1_000,
	parameter int unsigned max_ticks = 30_000
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic enable,
	input  logic tick,
	input  logic user_idle,
	input  logic save_ram_wr,
	input  logic ioctl_upload,
	output logic ioctl_upload_req
);

	// Timer and interval count in ticks, sized for the cap
	localparam int unsigned tmr_w = $clog2(max_ticks + 1);

	localparam logic [tmr_w-1:0] min_v = tmr_w'(min_ticks);
	localparam logic [tmr_w-1:0] max_v = tmr_w'(max_ticks);

	autosave_pkg::sched_state_t   state;
	autosave_pkg::check_outcome_t outcome;

	logic             dirty;
	logic [tmr_w-1:0] timer;
	logic [tmr_w-1:0] interval;
	logic [tmr_w-1:0] dbl_interval;
	logic [tmr_w-1:0] half_interval;
	logic             at_cap;
	logic             check_now;

	// ----------------------------------------------------------------------
	// Interval arithmetic
	// ----------------------------------------------------------------------

	// Doubling, clamped before the shift so it never overflows
	assign dbl_interval = (interval > (max_v >> 1)) ? max_v : (interval << 1);

	// Halving, floored at the minimum
	assign half_interval = ((interval >> 1) < min_v) ? min_v : (interval >> 1);

	// At the cap the idle guard no longer holds a save back
	assign at_cap = (interval >= max_v);

	// ----------------------------------------------------------------------
	// Dirty check
	// ----------------------------------------------------------------------

	// Evaluated in the single cycle the timer rests at zero
	assign check_now = enable && (state == autosave_pkg::sched_count)
		&& !ioctl_upload && (timer == '0);

	always_comb begin
		if (!dirty) begin
			outcome = autosave_pkg::check_relax;
		end else if (user_idle || at_cap) begin
			outcome = autosave_pkg::check_save;
		end else begin
			outcome = autosave_pkg::check_defer;
		end
	end

	// Write wins over the clear, a late write stays pending for next time
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dirty <= 1'b0;
		end else if (save_ram_wr) begin
			dirty <= 1'b1;
		end else if (check_now && outcome == autosave_pkg::check_save) begin
			dirty <= 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// Scheduler FSM
	// ----------------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset || !enable) begin
			// First check comes after the floor interval
			state            <= autosave_pkg::sched_count;
			timer            <= min_v;
			interval         <= min_v;
			ioctl_upload_req <= 1'b0;
		end else begin
			case (state)
				autosave_pkg::sched_count: begin
					if (check_now) begin
						case (outcome)
							autosave_pkg::check_save: begin
								// Timer reloads once the upload is over
								state            <= autosave_pkg::sched_upload;
								ioctl_upload_req <= 1'b1;
								interval         <= dbl_interval;
							end
							autosave_pkg::check_defer: begin
								interval <= dbl_interval;
								timer    <= dbl_interval;
							end
							default: begin
								interval <= half_interval;
								timer    <= half_interval;
							end
						endcase
					end else if (tick && !ioctl_upload && timer != '0) begin
						timer <= timer - 1'b1;
					end
				end
				autosave_pkg::sched_upload: begin
					// Request drops as soon as the host starts the upload
					if (ioctl_upload) begin
						ioctl_upload_req <= 1'b0;
					end else if (!ioctl_upload_req) begin
						timer <= interval;
						state <= autosave_pkg::sched_count;
					end
				end
				default: state <= autosave_pkg::sched_count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/activity_monitor.sv */
// Tick prescaler and activity monitor
`default_nettype none

module activity_monitor #(
	parameter int unsigned prescale   = 50_000,
	parameter int unsigned idle_ticks = 1_000
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic user_active,
	output logic tick,
	output logic user_idle
);

	// Counter widths, at least one bit each
	localparam int unsigned pre_w  = (prescale > 1) ? $clog2(prescale) : 1;
	localparam int unsigned idle_w = $clog2(idle_ticks + 1);

	localparam logic [pre_w-1:0]  pre_load  = pre_w'(prescale - 1);
	localparam logic [idle_w-1:0] idle_load = idle_w'(idle_ticks);

	logic [pre_w-1:0]  pre_cnt;
	logic              active_q;
	logic              active_edge;
	logic [idle_w-1:0] idle_cnt;

	// ----------------------------------------------------------------------
	// Prescaler
	// ----------------------------------------------------------------------

	// Down counter, reloads on the cycle it sits at zero
	always_ff @(posedge clk_sys) begin
		if (reset || pre_cnt == '0) begin
			pre_cnt <= pre_load;
		end else begin
			pre_cnt <= pre_cnt - 1'b1;
		end
	end

	// One pulse every prescale cycles
	assign tick = (pre_cnt == '0);

	// ----------------------------------------------------------------------
	// Idle tracking
	// ----------------------------------------------------------------------

	// Previous input level, also sampled in reset so no false edge follows it
	always_ff @(posedge clk_sys) begin
		active_q <= user_active;
	end

	// Any change counts as activity, level or toggle alike
	assign active_edge = (user_active != active_q);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			idle_cnt  <= '0;
			user_idle <= 1'b1;
		end else if (active_edge) begin
			// Restart the quiet period
			idle_cnt  <= idle_load;
			user_idle <= 1'b0;
		end else if (idle_cnt != '0) begin
			if (tick) begin
				idle_cnt <= idle_cnt - 1'b1;
			end
		end else begin
			user_idle <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/autosave_pkg.sv */
// Autosave shared definitions
`default_nettype none

package autosave_pkg;

	// ----------------------------------------------------------------------
	// Default save memory geometry
	// ----------------------------------------------------------------------

	// 8 KB of battery-backed RAM
	localparam int unsigned addr_w_def = 13;
	// One byte per host read
	localparam int unsigned data_w_def = 8;

	typedef logic [addr_w_def-1:0] save_addr_t;
	typedef logic [data_w_def-1:0] save_data_t;

	// ----------------------------------------------------------------------
	// State and decision codes
	// ----------------------------------------------------------------------

	// Scheduler, counting toward a check or waiting on the host upload
	typedef enum logic {
		sched_count,
		sched_upload
	} sched_state_t;

	// Result of one dirty check
	typedef enum logic [1:0] {
		check_save,
		check_defer,
		check_relax
	} check_outcome_t;

	// Upload server, one host read in flight at most
	typedef enum logic {
		serve_idle,
		serve_pending
	} serve_state_t;

endpackage

`default_nettype wire
